/* test/crono_tests.txt */
# name op a b c hold expected (a, b, c and expected in hex, hold in ticks)
# POS/VAL a=button code, CAP a=read b=address c=byte, ACK a=a_a, RST no operands
reset_inicial        RST 0 0 0  1 0
pos_derecha_1        POS 1 0 0  1 1
pos_derecha_2        POS 1 0 0  2 0
pos_izquierda_1      POS 2 0 0  1 2
pos_izquierda_3      POS 2 0 0  3 2
pos_inicio           POS 3 0 0  2 0
pos_reposo           POS 0 0 0  3 0
seg_sube_7           VAL 2 0 0  7 000007
seg_sube_cruce       VAL 2 0 0  5 000012
seg_baja_3           VAL 1 0 0  3 000009
seg_baja_envuelve    VAL 1 0 0 10 000059
seg_sube_envuelve    VAL 2 0 0  2 000001
pos_minutos          POS 1 0 0  1 1
min_baja_envuelve    VAL 1 0 0  1 005901
min_sube_2           VAL 2 0 0  2 000101
pos_horas            POS 1 0 0  1 2
hora_baja_envuelve   VAL 1 0 0  1 230101
hora_sube_envuelve   VAL 2 0 0  2 010101
hora_baja_2          VAL 1 0 0  2 230101
val_ambos            VAL 3 0 0  2 230101
reset_captura        RST 0 0 0  1 0
cap_seg              CAP 1 6 45 1 000045
cap_min              CAP 1 7 32 1 003245
cap_hora             CAP 1 8 17 1 173245
cap_reposo           CAP 0 6 11 2 173245
cap_borra            CAP 1 3 11 1 000000
cap_alarma           CAP 1 6 05 1 000005
alarma_ajuste        VAL 2 0 0  5 000005
alarma_activa        ACK 0 0 0  1 1
alarma_borra_ajuste  VAL 0 0 0  1 000000
alarma_ack           ACK 1 0 0  1 0
alarma_cero_cap      CAP 1 0 00 1 000000
alarma_cero          ACK 0 0 0  2 0

/* verilog.f */
+incdir+common
common/crono_pkg.sv
common/ajuste_if.sv
ajuste/selector_posicion.sv
ajuste/campo_bcd.sv
ajuste/ajuste_crono.sv
rtl/captura_rtc.sv
rtl/comparador_alarma.sv
rtl/bloque_crono.sv
test/gen_reloj.sv
test/tb_bloque_crono.sv

/* Bender.yml */
package:
  name: bloque_crono

sources:
  - include_dirs:
      - common
    files:
      - common/crono_pkg.sv
      - common/ajuste_if.sv
      - ajuste/selector_posicion.sv
      - ajuste/campo_bcd.sv
      - ajuste/ajuste_crono.sv
      - rtl/captura_rtc.sv
      - rtl/comparador_alarma.sv
      - rtl/bloque_crono.sv
  - target: test
    include_dirs:
      - common
    files:
      - test/gen_reloj.sv
      - test/tb_bloque_crono.sv

/* test/tb_bloque_crono.sv */
`include "chrono_macros.svh"

`default_nettype none

module tb_bloque_crono;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int    CICLO_NS    = 8;
   localparam int    CICLOS_TICK = 1 << `CRONO_TICK_W;
   localparam int    TICK_NS     = CICLO_NS * CICLOS_TICK;
   localparam string ARCHIVO     = "test/crono_tests.txt";

   logic                     reloj;
   logic                     resetM;
   logic [3:0]               selec_demux_dd;
   logic [`CRONO_BCD_W-1:0]  in_segcr;
   logic [`CRONO_BCD_W-1:0]  in_mincr;
   logic [`CRONO_BCD_W-1:0]  in_horacr;
   logic [3:0]               in_bot_cr;
   logic                     a_a;
   logic                     read;
   logic [`CRONO_TIME_W-1:0] alarma;
   logic [`CRONO_TIME_W-1:0] com_alarma;
   logic                     bit_alarma;
   logic [1:0]               contador_pos_cr;

   int          ciclos;
   int          errores;
   int          comprobaciones;
   int          limite_ns;
   bit          limite_listo;
   string       nombre_q[$];
   string       op_q[$];
   logic [63:0] arg_a_q[$];
   logic [63:0] arg_b_q[$];
   logic [63:0] arg_c_q[$];
   int          hold_q[$];
   logic [63:0] esperado_q[$];

   gen_reloj #(.MEDIO_PERIODO(CICLO_NS/2), .CICLOS_RESET(8)) u_gen
   (
      .reloj  (reloj),
      .resetM (resetM)
   );

   bloque_crono UUT
   (
      .reloj           (reloj),
      .resetM          (resetM),
      .selec_demux_dd  (selec_demux_dd),
      .in_segcr        (in_segcr),
      .in_mincr        (in_mincr),
      .in_horacr       (in_horacr),
      .in_bot_cr       (in_bot_cr),
      .a_a             (a_a),
      .read            (read),
      .alarma          (alarma),
      .com_alarma      (com_alarma),
      .bit_alarma      (bit_alarma),
      .contador_pos_cr (contador_pos_cr)
   );

   // Cycles since reset release
   always @(posedge reloj)
   begin
      if (resetM)
         ciclos <= 0;
      else
         ciclos <= ciclos + 1;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus helpers

   task automatic poner_reposo();
      in_bot_cr      = '0;
      selec_demux_dd = '0;
      in_segcr       = '0;
      in_mincr       = '0;
      in_horacr      = '0;
      a_a            = 1'b0;
      read           = 1'b0;
   endtask

   // Returns 1 ns after the edge that closes a tick cycle
   task automatic esperar_tick();
      do
      begin
         @(posedge reloj);
         #1;
      end
      while ((ciclos == 0) || (ciclos % CICLOS_TICK != 0));
   endtask

   task automatic leer_tests();
      int          fd;
      int          n;
      int          hold;
      string       nombre;
      string       op;
      string       resto;
      logic [63:0] a;
      logic [63:0] b;
      logic [63:0] c;
      logic [63:0] esperado;
      fd = $fopen(ARCHIVO, "r");
      if (fd == 0)
      begin
         $display("Could not open the test file %s", ARCHIVO);
         errores++;
         return;
      end
      while (!$feof(fd))
      begin
         n = $fscanf(fd, "%s", nombre);
         if (n != 1)
            break;
         if (nombre[0] == "#")
         begin
            n = $fgets(resto, fd);
            continue;
         end
         n = $fscanf(fd, "%s %h %h %h %d %h", op, a, b, c, hold, esperado);
         if (n != 6)
         begin
            $display("Test line %s in %s is malformed and was skipped", nombre, ARCHIVO);
            errores++;
            n = $fgets(resto, fd);
            continue;
         end
         nombre_q.push_back(nombre);
         op_q.push_back(op);
         arg_a_q.push_back(a);
         arg_b_q.push_back(b);
         arg_c_q.push_back(c);
         hold_q.push_back(hold);
         esperado_q.push_back(esperado);
      end
      $fclose(fd);
   endtask

   // Each operation is judged on its own output
   function automatic logic [63:0] observar(input string op);
      logic [63:0] r;
      r = '0;
      if (op == "RST")
         r = {alarma, com_alarma, bit_alarma, contador_pos_cr};
      else if (op == "POS")
         r = contador_pos_cr;
      else if (op == "VAL")
         r = alarma;
      else if (op == "CAP")
         r = com_alarma;
      else
         r = bit_alarma;
      return r;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // One test drives for hold ticks, idles one tick and compares

   task automatic ejecutar_test(input int i);
      logic [63:0] actual;
      bit          valido;
      valido = 1'b1;
      poner_reposo();
      if (op_q[i] == "RST")
         u_gen.aplicar_reset();
      else if (op_q[i] == "POS")
         in_bot_cr[1:0] = arg_a_q[i][1:0];
      else if (op_q[i] == "VAL")
         in_bot_cr[3:2] = arg_a_q[i][1:0];
      else if (op_q[i] == "CAP")
      begin
         read           = arg_a_q[i][0];
         selec_demux_dd = arg_b_q[i][3:0];
         // Registers not addressed carry a different byte
         in_segcr       = ~arg_c_q[i][7:0];
         in_mincr       = ~arg_c_q[i][7:0];
         in_horacr      = ~arg_c_q[i][7:0];
         case (arg_b_q[i][3:0])
            `CRONO_DIR_SEG:
               in_segcr = arg_c_q[i][7:0];
            `CRONO_DIR_MIN:
               in_mincr = arg_c_q[i][7:0];
            `CRONO_DIR_HORA:
               in_horacr = arg_c_q[i][7:0];
         endcase
      end
      else if (op_q[i] == "ACK")
         a_a = arg_a_q[i][0];
      else
      begin
         $display("Test %s has an unknown operation %s", nombre_q[i], op_q[i]);
         errores++;
         valido = 1'b0;
      end
      if (valido)
      begin
         repeat (hold_q[i])
            esperar_tick();
         poner_reposo();
         esperar_tick();
         actual = observar(op_q[i]);
         comprobaciones++;
         assert (actual == esperado_q[i])
         else
         begin
            $display("Fail %s: expected %h, actual %h", nombre_q[i], esperado_q[i], actual);
            errores++;
         end
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Main sequence and watchdog

   initial
   begin
      int total_hold;
      errores        = 0;
      comprobaciones = 0;
      total_hold     = 0;
      poner_reposo();
      leer_tests();
      foreach (hold_q[i])
         total_hold += hold_q[i];
      limite_ns    = 2 * total_hold * TICK_NS + 1000;
      limite_listo = 1'b1;
      @(negedge resetM);
      esperar_tick();
      foreach (nombre_q[i])
         ejecutar_test(i);
      $display("Checks: %0d, errors: %0d", comprobaciones, errores);
      if (errores == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

   initial
   begin
      wait (limite_listo);
      #(limite_ns);
      errores++;
      $display("Timeout after %0d ns, the test sequence did not finish", limite_ns);
      $display("Checks: %0d, errors: %0d", comprobaciones, errores);
      $display("FAIL: see errors above");
      $finish;
   end

endmodule

`default_nettype wire

/* test/gen_reloj.sv */
`default_nettype none

module gen_reloj
#(
   parameter int MEDIO_PERIODO = 4,
   parameter int CICLOS_RESET  = 8
)
(
   output logic reloj,
   output logic resetM
);
   timeunit 1ns;
   timeprecision 1ps;

   initial
   begin
      reloj = 1'b0;
      forever
         #MEDIO_PERIODO reloj = ~reloj;
   end

   // Release lands 1 ns after a rising edge
   task automatic aplicar_reset();
      resetM = 1'b1;
      repeat (CICLOS_RESET) @(posedge reloj);
      #1 resetM = 1'b0;
   endtask

   initial
      aplicar_reset();

endmodule

`default_nettype wire

/* rtl/bloque_crono.sv */
`include "chrono_macros.svh"

`default_nettype none

module bloque_crono
   import crono_pkg::*;
(
   input  wire logic                     reloj,
   input  wire logic                     resetM,
   input  wire logic [3:0]               selec_demux_dd,
   input  wire logic [`CRONO_BCD_W-1:0]  in_segcr,
   input  wire logic [`CRONO_BCD_W-1:0]  in_mincr,
   input  wire logic [`CRONO_BCD_W-1:0]  in_horacr,
   input  wire logic [3:0]               in_bot_cr,
   input  wire logic                     a_a,
   input  wire logic                     read,
   output logic      [`CRONO_TIME_W-1:0] alarma,
   output logic      [`CRONO_TIME_W-1:0] com_alarma,
   output logic                          bit_alarma,
   output logic      [1:0]               contador_pos_cr
);

   tiempo_u hora_ajuste;
   tiempo_u hora_leida;

   ajuste_crono u_ajuste
   (
      .reloj           (reloj),
      .resetM          (resetM),
      .in_bot_cr       (in_bot_cr),
      .borrar          (bit_alarma),
      .alarma          (hora_ajuste),
      .contador_pos_cr (contador_pos_cr)
   );

   captura_rtc u_captura
   (
      .reloj          (reloj),
      .resetM         (resetM),
      .read           (read),
      .selec_demux_dd (selec_demux_dd),
      .in_segcr       (in_segcr),
      .in_mincr       (in_mincr),
      .in_horacr      (in_horacr),
      .com_alarma     (hora_leida)
   );

   comparador_alarma u_comparador
   (
      .reloj      (reloj),
      .resetM     (resetM),
      .alarma     (hora_ajuste),
      .com_alarma (hora_leida),
      .a_a        (a_a),
      .bit_alarma (bit_alarma)
   );

   assign alarma     = hora_ajuste.crudo;
   assign com_alarma = hora_leida.crudo;

endmodule

`default_nettype wire

/* rtl/comparador_alarma.sv */
`default_nettype none

module comparador_alarma
   import crono_pkg::*;
(
   input  wire logic reloj,
   input  wire logic resetM,
   input  tiempo_u   alarma,
   input  tiempo_u   com_alarma,
   input  wire logic a_a,
   output logic      bit_alarma
);

   logic coincide;

   // Zero set time means no alarm programmed
   assign coincide = (alarma.crudo == com_alarma.crudo) && (alarma.crudo != '0);

   always_ff @(posedge reloj)
   begin
      if (resetM)
         bit_alarma <= 1'b0;
      else if (coincide && !a_a)
         bit_alarma <= 1'b1;
      else if (a_a)
         bit_alarma <= 1'b0;
   end

   a_sin_subida_ack: assert property (@(posedge reloj) disable iff (resetM)
      $rose(bit_alarma) |-> !$past(a_a))
      else $error("alarm bit rose under acknowledge");

   // Set bit feeds back as a clear of the set time
   a_borrado_ajuste: assert property (@(posedge reloj) disable iff (resetM)
      bit_alarma |=> (alarma.crudo == '0))
      else $error("set time not cleared after alarm");

endmodule

`default_nettype wire

/* rtl/captura_rtc.sv */
`include "chrono_macros.svh"

`default_nettype none

module captura_rtc
   import crono_pkg::*;
(
   input  wire logic       reloj,
   input  wire logic       resetM,
   input  wire logic       read,
   input  wire logic [3:0] selec_demux_dd,
   input  bcd_byte_u       in_segcr,
   input  bcd_byte_u       in_mincr,
   input  bcd_byte_u       in_horacr,
   output tiempo_u         com_alarma
);

   ////////////////////////////////////////////////////////////////////////////
   // Time bytes read back from the clock

   always_ff @(posedge reloj)
   begin
      if (resetM)
         com_alarma.crudo <= '0;
      else if (read)
      begin
         case (selec_demux_dd)
            `CRONO_DIR_SEG:
               com_alarma.campos.seg <= in_segcr;
            `CRONO_DIR_MIN:
               com_alarma.campos.min <= in_mincr;
            `CRONO_DIR_HORA:
               com_alarma.campos.hora <= in_horacr;
            // Read of any other register drops the captured time
            default:
               com_alarma.crudo <= '0;
         endcase
      end
   end

endmodule

`default_nettype wire

/* ajuste/ajuste_crono.sv */
`include "chrono_macros.svh"

`default_nettype none

module ajuste_crono
   import crono_pkg::*;
(
   input  wire logic       reloj,
   input  wire logic       resetM,
   input  wire logic [3:0] in_bot_cr,
   input  wire logic       borrar,
   output tiempo_u         alarma,
   output logic [1:0]      contador_pos_cr
);

   ajuste_if bus_ajuste ();

   bcd_byte_u dato_seg;
   bcd_byte_u dato_min;
   bcd_byte_u dato_hora;

   // Low pair moves the position, high pair steps the value
   assign bus_ajuste.botones_valor = in_bot_cr[3:2];
   assign bus_ajuste.borrar        = borrar;

   selector_posicion u_selector
   (
      .reloj       (reloj),
      .resetM      (resetM),
      .botones_pos (in_bot_cr[1:0]),
      .bus         (bus_ajuste.selector)
   );

   campo_bcd #(.MAX(`CRONO_MAX_SEG), .POS(`CRONO_POS_SEG)) u_seg
   (
      .reloj  (reloj),
      .resetM (resetM),
      .bus    (bus_ajuste.campo),
      .dato   (dato_seg)
   );

   campo_bcd #(.MAX(`CRONO_MAX_SEG), .POS(`CRONO_POS_MIN)) u_min
   (
      .reloj  (reloj),
      .resetM (resetM),
      .bus    (bus_ajuste.campo),
      .dato   (dato_min)
   );

   campo_bcd #(.MAX(`CRONO_MAX_HORA), .POS(`CRONO_POS_HORA)) u_hora
   (
      .reloj  (reloj),
      .resetM (resetM),
      .bus    (bus_ajuste.campo),
      .dato   (dato_hora)
   );

   assign alarma.campos    = '{hora: dato_hora, min: dato_min, seg: dato_seg};
   assign contador_pos_cr  = bus_ajuste.posicion;

endmodule

`default_nettype wire

/* ajuste/campo_bcd.sv */
`include "chrono_macros.svh"

`default_nettype none

module campo_bcd
   import crono_pkg::*;
#(
   parameter logic [`CRONO_BCD_W-1:0] MAX = `CRONO_MAX_SEG,
   parameter logic [1:0]              POS = `CRONO_POS_SEG
)
(
   input  wire logic reloj,
   input  wire logic resetM,
   ajuste_if.campo   bus,
   output bcd_byte_u dato
);

   logic [1:0] pendiente;
   logic       activo;
   bcd_byte_u  siguiente;

   // Only the selected field moves, and only on a tick
   assign activo = bus.tick && (bus.posicion == POS);

   ////////////////////////////////////////////////////////////////////////////
   // Step with digit carry and wrap

   always_comb
   begin
      siguiente = dato;
      case (pendiente)
         2'b10:
         begin
            if (dato.crudo == MAX)
               siguiente.crudo = '0;
            else if (dato.digitos.unidades == 4'd9)
            begin
               siguiente.digitos.decenas  = dato.digitos.decenas + 4'd1;
               siguiente.digitos.unidades = 4'd0;
            end
            else
               siguiente.digitos.unidades = dato.digitos.unidades + 4'd1;
         end
         2'b01:
         begin
            if (dato.crudo == '0)
               siguiente.crudo = MAX;
            else if (dato.digitos.unidades == 4'd0)
            begin
               siguiente.digitos.decenas  = dato.digitos.decenas - 4'd1;
               siguiente.digitos.unidades = 4'd9;
            end
            else
               siguiente.digitos.unidades = dato.digitos.unidades - 4'd1;
         end
         // 00 and 11 leave the field alone
         default:
         begin
            siguiente = dato;
         end
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // Field register and pending step

   always_ff @(posedge reloj)
   begin
      if (resetM || bus.borrar)
      begin
         dato.crudo <= '0;
         pendiente  <= 2'b00;
      end
      else if (activo)
      begin
         dato      <= siguiente;
         pendiente <= bus.botones_valor;
      end
   end

   a_dato_bcd: assert property (@(posedge reloj) disable iff (resetM)
      (dato.digitos.unidades <= 4'd9) && (dato.digitos.decenas <= 4'd9)
      && (dato.crudo <= MAX))
      else $error("field holds %h, limit %h", dato.crudo, MAX);

endmodule

`default_nettype wire

/* ajuste/selector_posicion.sv */
`include "chrono_macros.svh"

`default_nettype none

module selector_posicion
(
   input  wire logic       reloj,
   input  wire logic       resetM,
   input  wire logic [1:0] botones_pos,
   ajuste_if.selector      bus
);

   logic [`CRONO_TICK_W-1:0] divisor;
   logic [1:0]               pos_sig;

   ////////////////////////////////////////////////////////////////////////////
   // Setting tick

   always_ff @(posedge reloj)
   begin
      if (resetM)
         divisor <= '0;
      else
         divisor <= divisor + 1'b1;
   end

   // Last cycle of each divider round
   assign bus.tick = &divisor;

   ////////////////////////////////////////////////////////////////////////////
   // Position FSM

   always_comb
   begin
      case (botones_pos)
         2'b01:
            pos_sig = (bus.posicion == `CRONO_POS_HORA) ? `CRONO_POS_SEG
                                                         : bus.posicion + 2'd1;
         2'b10:
            pos_sig = (bus.posicion == `CRONO_POS_SEG) ? `CRONO_POS_HORA
                                                        : bus.posicion - 2'd1;
         2'b11:
            pos_sig = `CRONO_POS_SEG;
         default:
            pos_sig = bus.posicion;
      endcase
   end

   always_ff @(posedge reloj)
   begin
      if (resetM)
         bus.posicion <= `CRONO_POS_SEG;
      else if (bus.tick)
         bus.posicion <= pos_sig;
   end

   a_pos_rango: assert property (@(posedge reloj) disable iff (resetM)
      bus.posicion != 2'd3)
      else $error("position left the three fields");

endmodule

`default_nettype wire

/* common/ajuste_if.sv */
`default_nettype none

interface ajuste_if;

   logic       tick;
   logic [1:0] posicion;
   // 10 up, 01 down
   logic [1:0] botones_valor;
   logic       borrar;

   modport selector
   (
      output tick,
      output posicion
   );

   modport campo
   (
      input tick,
      input posicion,
      input botones_valor,
      input borrar
   );

endinterface

`default_nettype wire

/* common/crono_pkg.sv */
`include "chrono_macros.svh"

`default_nettype none

package crono_pkg;

   typedef struct packed
   {
      logic [`CRONO_BCD_W/2-1:0] decenas;
      logic [`CRONO_BCD_W/2-1:0] unidades;
   } bcd_digitos_t;

   // Raw byte for limit tests, digits for stepping
   typedef union packed
   {
      logic [`CRONO_BCD_W-1:0] crudo;
      bcd_digitos_t            digitos;
   } bcd_byte_u;

   typedef struct packed
   {
      bcd_byte_u hora;
      bcd_byte_u min;
      bcd_byte_u seg;
   } tiempo_campos_t;

   typedef union packed
   {
      logic [`CRONO_TIME_W-1:0] crudo;
      tiempo_campos_t           campos;
   } tiempo_u;

endpackage

`default_nettype wire

/* common/chrono_macros.svh */
`ifndef CHRONO_MACROS_SVH
`define CHRONO_MACROS_SVH

`default_nettype none

// Field and word widths
`define CRONO_BCD_W     8
`define CRONO_TIME_W    24

// Upper limits of each field, in BCD
`define CRONO_MAX_SEG   8'h59
`define CRONO_MAX_HORA  8'h23

// Clock registers holding the current time
`define CRONO_DIR_SEG   4'h6
`define CRONO_DIR_MIN   4'h7
`define CRONO_DIR_HORA  4'h8

// One setting tick every 2**W cycles
`define CRONO_TICK_W    2

// Field positions
`define CRONO_POS_SEG   2'd0
`define CRONO_POS_MIN   2'd1
`define CRONO_POS_HORA  2'd2

`default_nettype wire

`endif
